//--- Makefile
VERILATOR ?= verilator
TOP       ?= scoreboard_display_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
source/display_pkg.sv
source/lcd_bus_if.sv
source/choice_led.sv
source/seg_scan.sv
source/lcd_message_rom.sv
source/lcd_sequencer.sv
source/scoreboard_display.sv
sim/scoreboard_display_props.sv
sim/scoreboard_display_tb.sv

//--- sim/scoreboard_display_props.sv
module scoreboard_display_props #(
    parameter bit SCAN = 1'b0   // Selects the scan checks instead of the LCD checks
) (
    input logic                           clk,
    input logic                           rst,
    input logic                           e,
    input logic                           rs,
    input logic                           rw,
    input logic [display_pkg::DIGITS-1:0] digit_sel
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = display_pkg::DIGITS;

    if (SCAN) begin : g_scan
        assert property (@(posedge clk) disable iff (!rst) $onehot(~digit_sel))
            else $error("digit_sel does not have exactly one active digit");

        // Active digit moves up by one each cycle
        assert property (@(posedge clk) disable iff (!rst)
            $past(rst) |-> digit_sel == {$past(digit_sel[N-2:0]), $past(digit_sel[N-1])})
            else $error("digit_sel skipped or repeated a digit");
    end else begin : g_lcd
        assert property (@(posedge clk) disable iff (!rst) e |-> !rw)
            else $error("LCD rw high during a write strobe");

        assert property (@(posedge clk) disable iff (!rst) $rose(e) |-> !rs)
            else $error("LCD strobe run does not open with a command byte");
    end

endmodule

bind lcd_sequencer scoreboard_display_props #(.SCAN(1'b0)) u_lcd_props (
    .clk       (clk),
    .rst       (rst),
    .e         (lcd.e),
    .rs        (lcd.rs),
    .rw        (lcd.rw),
    .digit_sel ('1)
);

bind seg_scan scoreboard_display_props #(.SCAN(1'b1)) u_scan_props (
    .clk       (clk),
    .rst       (rst),
    .e         (1'b0),
    .rs        (1'b0),
    .rw        (1'b0),
    .digit_sel (digit_sel)
);

//--- sim/scoreboard_display_tb.sv
module scoreboard_display_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 rst;
    display_pkg::choice_t choice1;
    display_pkg::choice_t choice2;
    display_pkg::score_t  score1;
    display_pkg::score_t  score2;
    display_pkg::result_t result;
    logic [2:0]           led1_rgb;
    logic [2:0]           led2_rgb;
    logic [6:0]           seg;
    logic [7:0]           digit_sel;
    logic                 lcd_e;
    logic                 lcd_rs;
    logic                 lcd_rw;
    logic [7:0]           lcd_data;

    int          cyc;   // Cycles since reset release
    int          errors;
    int          checks;
    int          tests;
    int          test_base;
    logic [15:0] lfsr_state;

    scoreboard_display DUT (
        .clk       (clk),
        .rst       (rst),
        .choice1   (choice1),
        .choice2   (choice2),
        .score1    (score1),
        .score2    (score2),
        .result    (result),
        .led1_rgb  (led1_rgb),
        .led2_rgb  (led2_rgb),
        .seg       (seg),
        .digit_sel (digit_sel),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;   // Taps 16, 14, 13, 11
        end
        return n;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] rgb_expected(input logic [1:0] c);
        case (c)
            2'd1:    return 3'b100;
            2'd2:    return 3'b010;
            2'd3:    return 3'b001;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [6:0] seg_expected(input logic [2:0] s);
        case (s)
            3'd1:    return 7'h06;
            3'd2:    return 7'h5B;
            3'd3:    return 7'h4F;
            3'd4:    return 7'h66;
            3'd5:    return 7'h6D;
            default: return 7'h7F;
        endcase
    endfunction

    // Text of the win message, column 0 holds the address
    function automatic logic [7:0] char_expected(input logic [1:0] res, input int ln, input int col);
        if (res != 2'd1 && res != 2'd2) return 8'h20;
        if (ln == 0) begin
            case (col)
                2:       return 8'h50;
                3:       return (res == 2'd1) ? 8'h31 : 8'h32;
                5:       return 8'h57;
                6:       return 8'h69;
                7:       return 8'h6E;
                default: return 8'h20;
            endcase
        end
        if (col inside {2, 3, 4, 6, 7, 8}) return 8'h9D;
        return 8'h20;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic wait_strobe(input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!lcd_e && n < limit);
        if (!lcd_e) begin
            errors++;
            $display("Timeout at %0t: no LCD strobe for the %s within %0d cycles",
                     $time, what, limit);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    // Two lines of bytes, then HOME and CLEAR
    task automatic frame_bytes(input logic [1:0] res, input int start,
                               input int change_idx, input logic [1:0] change_to);
        int ln;
        int col;
        for (int i = 0; i < 42; i++) begin
            wait_strobe(1000, "line byte");
            ln = i / 21;
            col = i % 21;
            compare("strobe cycle", cyc, start + i);
            compare("lcd_rw", lcd_rw, 1'b0);
            if (col == 0) begin
                compare("lcd_rs", lcd_rs, 1'b0);
                compare("lcd_data", lcd_data, (ln == 0) ? 8'h80 : 8'hC0);
            end else begin
                compare("lcd_rs", lcd_rs, 1'b1);
                compare("lcd_data", lcd_data, char_expected(res, ln, col));
            end
            if (i == change_idx) begin
                @(posedge clk);
                result <= change_to;
            end
        end
        wait_strobe(1000, "home command");
        compare("strobe cycle", cyc, start + 42);
        compare("lcd_rs", lcd_rs, 1'b0);
        compare("lcd_data", lcd_data, 8'h02);
        wait_strobe(1000, "clear command");
        compare("strobe cycle", cyc, start + 42 + 401);
        compare("lcd_rs", lcd_rs, 1'b0);
        compare("lcd_data", lcd_data, 8'h01);
    endtask

    initial begin
        logic [1:0] prev1;
        logic [1:0] prev2;
        logic [1:0] r1;
        logic [1:0] r2;
        logic [2:0] s1;
        logic [2:0] s2;
        logic [6:0] exp_seg;
        logic [7:0] exp_sel;
        int         start;
        int         exp_cyc[3];
        logic [7:0] exp_cmd[3];

        clk = 1'b0;
        rst = 1'b0;
        choice1 = '0;
        choice2 = '0;
        score1 = '0;
        score2 = '0;
        result = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_base = 0;
        lfsr_state = 16'd5;
        exp_cyc = '{71, 102, 133};
        exp_cmd = '{8'h3C, 8'h06, 8'h0C};

        apply_reset();
        prev1 = choice1;
        prev2 = choice2;
        for (int i = 0; i < 100; i++) begin
            r1 = rand_bits(2);
            r2 = rand_bits(2);
            @(posedge clk);
            choice1 <= r1;
            choice2 <= r2;
            @(negedge clk);
            compare("led1_rgb", led1_rgb, rgb_expected(prev1));   // One cycle of latency
            compare("led2_rgb", led2_rgb, rgb_expected(prev2));
            prev1 = r1;
            prev2 = r2;
        end
        report_test("led decode");

        for (int i = 0; i < 64; i++) begin
            s1 = rand_bits(3);
            s2 = rand_bits(3);
            @(posedge clk);
            score1 <= s1;
            score2 <= s2;
            @(negedge clk);
            exp_sel = ~(8'b1 << (cyc % 8));
            compare("digit_sel", digit_sel, exp_sel);
            exp_seg = 7'h00;
            if (cyc % 8 == 0) exp_seg = seg_expected(s1);
            if (cyc % 8 == 7) exp_seg = seg_expected(s2);
            compare("seg", seg, exp_seg);
        end
        report_test("digit scan");

        apply_reset();   // LCD timing counts from here
        for (int i = 0; i < 3; i++) begin
            wait_strobe(200, "init command");
            compare("strobe cycle", cyc, exp_cyc[i]);
            compare("lcd_rs", lcd_rs, 1'b0);
            compare("lcd_rw", lcd_rw, 1'b0);
            compare("lcd_data", lcd_data, exp_cmd[i]);
        end
        report_test("lcd init");

        start = 164;
        for (int f = 0; f < 3; f++) begin
            r1 = rand_bits(2);
            @(posedge clk);
            result <= r1;
            frame_bytes(r1, start, -1, 2'd0);
            start += 644;
        end
        report_test("lcd frames");

        r1 = rand_bits(1) ? 2'd2 : 2'd1;
        r2 = (r1 == 2'd1) ? 2'd2 : 2'd1;
        @(posedge clk);
        result <= r1;
        frame_bytes(r1, start, 1, r2);   // New result arrives before the player digit
        start += 644;
        frame_bytes(r2, start, -1, 2'd0);
        report_test("mid-frame result change");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- source/choice_led.sv
module choice_led (
    input  logic                 clk,
    input  logic                 rst,
    input  display_pkg::choice_t choice1,
    input  display_pkg::choice_t choice2,
    output logic [2:0]           led1_rgb,
    output logic [2:0]           led2_rgb
);

    // Bit order is r, g, b
    function automatic logic [2:0] rgb_of(input display_pkg::choice_t c);
        logic [2:0] rgb;
        unique case (c)
            display_pkg::CHOICE_NONE:  rgb = 3'b000;
            display_pkg::CHOICE_RED:   rgb = 3'b100;
            display_pkg::CHOICE_GREEN: rgb = 3'b010;
            display_pkg::CHOICE_BLUE:  rgb = 3'b001;
        endcase
        return rgb;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            led1_rgb <= 3'b000;
            led2_rgb <= 3'b000;
        end else begin
            led1_rgb <= rgb_of(choice1);
            led2_rgb <= rgb_of(choice2);
        end
    end

endmodule

//--- source/display_pkg.sv
package display_pkg;

    // Player inputs
    typedef logic [1:0] choice_t;
    typedef logic [1:0] result_t;
    typedef logic [2:0] score_t;

    localparam choice_t CHOICE_NONE  = 2'd0;
    localparam choice_t CHOICE_RED   = 2'd1;
    localparam choice_t CHOICE_GREEN = 2'd2;
    localparam choice_t CHOICE_BLUE  = 2'd3;

    localparam result_t RESULT_NONE = 2'd0;
    localparam result_t RESULT_P1   = 2'd1;
    localparam result_t RESULT_P2   = 2'd2;

    // Display geometry
    localparam int SEG_W  = 7;
    localparam int DIGITS = 8;
    localparam int LCD_W  = 8;
    localparam int COL_W  = 5;   // LCD column index
    localparam int IV_W   = 9;   // Interval counter, longest stay is 401

    localparam logic [SEG_W-1:0] SEG_BLANK = 7'b111_1111;

    // LCD controller states
    typedef enum logic [2:0] {
        POWER_WAIT,
        FUNC_SET,
        ENTRY_MODE,
        DISP_ON,
        LINE1,
        LINE2,
        HOME,
        CLEAR
    } lcd_state_t;

    // Stay lengths in cycles
    localparam logic [IV_W-1:0] T_POWER = 9'd71;
    localparam logic [IV_W-1:0] T_CMD   = 9'd31;
    localparam logic [IV_W-1:0] T_LINE  = 9'd21;   // Address plus 20 characters
    localparam logic [IV_W-1:0] T_HOME  = 9'd401;
    localparam logic [IV_W-1:0] T_CLEAR = 9'd201;

    // LCD command bytes
    localparam logic [LCD_W-1:0] CMD_FUNC  = 8'h3C;   // 8-bit bus, two lines
    localparam logic [LCD_W-1:0] CMD_ENTRY = 8'h06;
    localparam logic [LCD_W-1:0] CMD_DISP  = 8'h0C;   // Display on, no cursor
    localparam logic [LCD_W-1:0] CMD_HOME  = 8'h02;
    localparam logic [LCD_W-1:0] CMD_CLEAR = 8'h01;

    localparam logic [LCD_W-1:0] ADDR_LINE1 = 8'h80;
    localparam logic [LCD_W-1:0] ADDR_LINE2 = 8'hC0;

    // Character codes
    localparam logic [LCD_W-1:0] CH_SPACE = 8'h20;
    localparam logic [LCD_W-1:0] CH_HEART = 8'h9D;   // Heart glyph in the module ROM
    localparam logic [LCD_W-1:0] CH_P     = 8'h50;
    localparam logic [LCD_W-1:0] CH_ONE   = 8'h31;
    localparam logic [LCD_W-1:0] CH_TWO   = 8'h32;
    localparam logic [LCD_W-1:0] CH_W     = 8'h57;
    localparam logic [LCD_W-1:0] CH_I     = 8'h69;
    localparam logic [LCD_W-1:0] CH_N     = 8'h6E;

endpackage

//--- source/lcd_bus_if.sv
interface lcd_bus_if;

    logic                          e;      // One byte per high cycle
    logic                          rs;
    logic                          rw;
    logic [display_pkg::LCD_W-1:0] data;

    modport source (output e, rs, rw, data);
    modport sink   (input e, rs, rw, data);

endinterface

//--- source/lcd_message_rom.sv
module lcd_message_rom (
    input  display_pkg::result_t             result,
    input  logic                             line,
    input  logic [display_pkg::COL_W-1:0]    col,
    output logic [display_pkg::LCD_W-1:0]    ch
);

    logic win;
    logic [display_pkg::LCD_W-1:0] player_ch;

    assign win = (result == display_pkg::RESULT_P1) || (result == display_pkg::RESULT_P2);
    assign player_ch = (result == display_pkg::RESULT_P1) ? display_pkg::CH_ONE
                                                          : display_pkg::CH_TWO;

    always_comb begin
        ch = display_pkg::CH_SPACE;   // Blank unless a column matches below
        if (win) begin
            if (!line) begin
                // " P1 Win" or " P2 Win"
                case (col)
                    5'd2:    ch = display_pkg::CH_P;
                    5'd3:    ch = player_ch;
                    5'd5:    ch = display_pkg::CH_W;
                    5'd6:    ch = display_pkg::CH_I;
                    5'd7:    ch = display_pkg::CH_N;
                    default: ch = display_pkg::CH_SPACE;
                endcase
            end else begin
                // Two groups of three hearts
                case (col)
                    5'd2, 5'd3, 5'd4: ch = display_pkg::CH_HEART;
                    5'd6, 5'd7, 5'd8: ch = display_pkg::CH_HEART;
                    default:          ch = display_pkg::CH_SPACE;
                endcase
            end
        end
    end

endmodule

//--- source/lcd_sequencer.sv
module lcd_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  display_pkg::result_t result,
    lcd_bus_if.source            lcd
);

    display_pkg::lcd_state_t         state;
    logic [display_pkg::IV_W-1:0]    interval;
    logic [display_pkg::IV_W-1:0]    stay;
    display_pkg::lcd_state_t         next_state;
    display_pkg::result_t            result_q;
    logic [display_pkg::LCD_W-1:0]   rom_ch;
    logic                            first;

    lcd_message_rom u_rom (
        .result (result_q),
        .line   (state == display_pkg::LINE2),
        .col    (interval[display_pkg::COL_W-1:0]),
        .ch     (rom_ch)
    );

    assign first = (interval == '0);

    // Stay length and successor of each state
    always_comb begin
        case (state)
            display_pkg::POWER_WAIT: begin
                stay       = display_pkg::T_POWER;
                next_state = display_pkg::FUNC_SET;
            end
            display_pkg::FUNC_SET: begin
                stay       = display_pkg::T_CMD;
                next_state = display_pkg::ENTRY_MODE;
            end
            display_pkg::ENTRY_MODE: begin
                stay       = display_pkg::T_CMD;
                next_state = display_pkg::DISP_ON;
            end
            display_pkg::DISP_ON: begin
                stay       = display_pkg::T_CMD;
                next_state = display_pkg::LINE1;
            end
            display_pkg::LINE1: begin
                stay       = display_pkg::T_LINE;
                next_state = display_pkg::LINE2;
            end
            display_pkg::LINE2: begin
                stay       = display_pkg::T_LINE;
                next_state = display_pkg::HOME;
            end
            display_pkg::HOME: begin
                stay       = display_pkg::T_HOME;
                next_state = display_pkg::CLEAR;
            end
            default: begin
                stay       = display_pkg::T_CLEAR;
                next_state = display_pkg::LINE1;   // Next frame
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= display_pkg::POWER_WAIT;
            interval <= '0;
            result_q <= display_pkg::RESULT_NONE;
        end else begin
            if (interval == stay - 1'b1) begin
                state    <= next_state;
                interval <= '0;
            end else begin
                interval <= interval + 1'b1;
            end
            // One message per frame
            if (state == display_pkg::LINE1 && first) begin
                result_q <= result;
            end
        end
    end

    always_comb begin
        lcd.e    = 1'b0;
        lcd.rs   = 1'b0;
        lcd.rw   = 1'b0;
        lcd.data = '0;
        case (state)
            display_pkg::POWER_WAIT: begin
                lcd.rs = 1'b1;   // Bus idle while the module powers up
                lcd.rw = 1'b1;
            end
            display_pkg::FUNC_SET: begin
                lcd.e    = first;
                lcd.data = display_pkg::CMD_FUNC;
            end
            display_pkg::ENTRY_MODE: begin
                lcd.e    = first;
                lcd.data = display_pkg::CMD_ENTRY;
            end
            display_pkg::DISP_ON: begin
                lcd.e    = first;
                lcd.data = display_pkg::CMD_DISP;
            end
            display_pkg::LINE1, display_pkg::LINE2: begin
                lcd.e = 1'b1;   // Byte on every cycle of a line
                if (first) begin
                    lcd.data = (state == display_pkg::LINE1) ? display_pkg::ADDR_LINE1
                                                             : display_pkg::ADDR_LINE2;
                end else begin
                    lcd.rs   = 1'b1;
                    lcd.data = rom_ch;
                end
            end
            display_pkg::HOME: begin
                lcd.e    = first;
                lcd.data = display_pkg::CMD_HOME;
            end
            default: begin
                lcd.e    = first;
                lcd.data = display_pkg::CMD_CLEAR;
            end
        endcase
    end

endmodule

//--- source/scoreboard_display.sv
module scoreboard_display (
    input  logic                            clk,
    input  logic                            rst,
    input  display_pkg::choice_t            choice1,
    input  display_pkg::choice_t            choice2,
    input  display_pkg::score_t             score1,
    input  display_pkg::score_t             score2,
    input  display_pkg::result_t            result,
    output logic [2:0]                      led1_rgb,
    output logic [2:0]                      led2_rgb,
    output logic [display_pkg::SEG_W-1:0]   seg,
    output logic [display_pkg::DIGITS-1:0]  digit_sel,
    output logic                            lcd_e,
    output logic                            lcd_rs,
    output logic                            lcd_rw,
    output logic [display_pkg::LCD_W-1:0]   lcd_data
);

    lcd_bus_if lcd_bus ();

    choice_led u_choice_led (
        .clk      (clk),
        .rst      (rst),
        .choice1  (choice1),
        .choice2  (choice2),
        .led1_rgb (led1_rgb),
        .led2_rgb (led2_rgb)
    );

    seg_scan u_seg_scan (
        .clk       (clk),
        .rst       (rst),
        .score1    (score1),
        .score2    (score2),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    lcd_sequencer u_lcd_sequencer (
        .clk    (clk),
        .rst    (rst),
        .result (result),
        .lcd    (lcd_bus.source)
    );

    // LCD pins
    assign lcd_e    = lcd_bus.e;
    assign lcd_rs   = lcd_bus.rs;
    assign lcd_rw   = lcd_bus.rw;
    assign lcd_data = lcd_bus.data;

endmodule

//--- source/seg_scan.sv
module seg_scan (
    input  logic                            clk,
    input  logic                            rst,
    input  display_pkg::score_t             score1,
    input  display_pkg::score_t             score2,
    output logic [display_pkg::SEG_W-1:0]   seg,
    output logic [display_pkg::DIGITS-1:0]  digit_sel
);

    logic [$clog2(display_pkg::DIGITS)-1:0] digit;

    // Score to segment pattern
    function automatic logic [display_pkg::SEG_W-1:0] seg_of(input display_pkg::score_t s);
        logic [display_pkg::SEG_W-1:0] p;
        case (s)
            3'd1:    p = 7'h06;
            3'd2:    p = 7'h5B;
            3'd3:    p = 7'h4F;
            3'd4:    p = 7'h66;
            3'd5:    p = 7'h6D;
            default: p = display_pkg::SEG_BLANK;   // Out of range score
        endcase
        return p;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            digit <= '0;
        end else begin
            digit <= digit + 1'b1;   // Wraps after the last digit
        end
    end

    // Active low anode select
    always_comb begin
        for (int k = 0; k < display_pkg::DIGITS; k++) begin
            digit_sel[k] = (digit != k);
        end
    end

    // Scores sit on the outer digits
    always_comb begin
        if (digit == '0) begin
            seg = seg_of(score1);
        end else if (digit == display_pkg::DIGITS - 1) begin
            seg = seg_of(score2);
        end else begin
            seg = '0;
        end
    end

endmodule
